// ==== qsim_pkg.sv ====
package qsim_pkg;

  // ------------------------------------------------------------
  // sizes
  // ------------------------------------------------------------

  // largest state vector is 2^4 amplitudes
  localparam int MAX_QUBITS = 4;
  // one real or imaginary part
  localparam int DATA_W = 32;
  // all four srams share this address width
  localparam int ADDR_W = 16;

  // ------------------------------------------------------------
  // word formats
  // ------------------------------------------------------------

  // signed part, wraps modulo 2^32
  typedef logic signed [DATA_W-1:0] part_t;

  // complex amplitude, real half on top
  // same layout in input, scratchpad, output and gates memories
  typedef struct packed {
    part_t re;
    part_t im;
  } amp_t;

  typedef logic [ADDR_W-1:0] addr_t;

  // word 0 of the input sram
  typedef struct packed {
    logic [DATA_W-1:0] qubits;
    logic [DATA_W-1:0] gates;
  } hdr_t;

  // ------------------------------------------------------------
  // controller states
  // ------------------------------------------------------------
  typedef enum logic [2:0] {
    reset_st,
    idle,
    load_hdr,
    setup,
    sweep,
    drain,
    next_gate
  } ctrl_state_t;

endpackage

// ==== sweep_if.sv ====
interface sweep_if
  import qsim_pkg::*;
();

  // holds the sweep idle, counters and strobes cleared
  logic  clr;
  // low reads input sram and writes scratchpad
  logic  rd_scratch;
  // products per gate, N*N
  addr_t n_sq;
  // N-1, picks the column out of the product count
  addr_t row_mask;
  // first word of the current gate in the gates sram
  addr_t gate_base;
  // level, high once the last row of the gate is written
  logic  done;

  // controller side
  modport ctrl (
    output clr, rd_scratch, n_sq, row_mask, gate_base,
    input  done
  );

  // address sweep side
  modport sweep (
    input  clr, rd_scratch, n_sq, row_mask, gate_base,
    output done
  );

endinterface

// ==== qsim_ctrl.sv ====
module qsim_ctrl
  import qsim_pkg::*;
#(
  parameter int max_qubits = MAX_QUBITS
) (
  input  logic         clk,
  input  logic         reset_n,
  input  logic         dut_valid,
  output logic         dut_ready,
  input  amp_t         hdr_word,
  sweep_if.ctrl        sw
);

  // qubit count needs to hold max_qubits itself
  localparam int QW = $clog2(max_qubits + 1);
  // N*N can reach 2^(2*max_qubits)
  localparam int NSQ_W = 2 * max_qubits + 1;

  ctrl_state_t           state;
  ctrl_state_t           state_nxt;
  hdr_t                  hdr;
  logic [QW-1:0]         q_r;
  logic [NSQ_W-1:0]      n_sq_r;
  logic [max_qubits-1:0] mask_r;
  logic [DATA_W-1:0]     gates_left;
  addr_t                 base_r;
  logic                  rd_scratch_r;

  // header sits on the input read data while the sweep is cleared
  assign hdr = hdr_t'(hdr_word);

  // ------------------------------------------------------------
  // outputs
  // ------------------------------------------------------------
  assign dut_ready     = (state == idle);
  // sweep only runs in its own state
  assign sw.clr        = (state != sweep);
  assign sw.rd_scratch = rd_scratch_r;
  assign sw.n_sq       = addr_t'(n_sq_r);
  assign sw.row_mask   = addr_t'(mask_r);
  assign sw.gate_base  = base_r;

  // ------------------------------------------------------------
  // job fsm
  // ------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      state <= reset_st;
    end else begin
      state <= state_nxt;
    end
  end

  always_comb begin
    state_nxt = state;
    case (state)
      reset_st:  state_nxt = idle;
      idle: begin
        if (dut_valid) state_nxt = load_hdr;
      end
      load_hdr:  state_nxt = setup;
      setup:     state_nxt = sweep;
      // wait for the last row write of this gate
      sweep: begin
        if (sw.done) state_nxt = drain;
      end
      // one cleared cycle drops done
      drain:     state_nxt = next_gate;
      // last gate ends the job, ready comes back via reset_st
      next_gate: state_nxt = (gates_left == 1) ? reset_st : sweep;
      default:   state_nxt = reset_st;
    endcase
  end

  // ------------------------------------------------------------
  // job geometry
  // ------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (state == load_hdr) begin
      q_r <= QW'(hdr.qubits);
    end
    if (state == setup) begin
      // N*N = 2^(2Q)
      n_sq_r <= NSQ_W'(1) << (2 * q_r);
      mask_r <= max_qubits'((NSQ_W'(1) << q_r) - 1'b1);
    end
  end

  // gate counter, gate offset, ping-pong select
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      gates_left   <= '0;
      base_r       <= '0;
      rd_scratch_r <= 1'b0;
    end else begin
      case (state)
        load_hdr: gates_left <= hdr.gates;
        // first gate reads the input sram
        setup: begin
          base_r       <= '0;
          rd_scratch_r <= 1'b0;
        end
        // next matrix starts one gate stride further on
        next_gate: begin
          gates_left   <= gates_left - 1'b1;
          base_r       <= base_r + addr_t'(n_sq_r);
          rd_scratch_r <= !rd_scratch_r;
        end
        default: ;
      endcase
    end
  end

  // encoding has one spare code, never entered
  state_legal: assert property (@(posedge clk) disable iff (!reset_n)
    state inside {reset_st, idle, load_hdr, setup, sweep, drain, next_gate});

endmodule

// ==== addr_sweep.sv ====
module addr_sweep
  import qsim_pkg::*;
#(
  parameter int max_qubits = MAX_QUBITS
) (
  input  logic   clk,
  input  logic   reset_n,
  sweep_if.sweep sw,
  output addr_t  gate_addr,
  output addr_t  state_rd_addr,
  output addr_t  out_wr_addr,
  output addr_t  input_wr_addr,
  output addr_t  scratch_wr_addr,
  output logic   input_we,
  output logic   scratch_we,
  output logic   out_we,
  output logic   term_valid,
  output logic   row_first
);

  // product counter spans N*N - 1
  localparam int CNT_W = 2 * max_qubits;
  // address reg to write strobe
  // read, products, sum, accumulate
  localparam int WR_LAT = 4;

  logic [CNT_W-1:0]      cnt;
  logic [max_qubits-1:0] col;
  logic [max_qubits-1:0] wr_row;
  logic                  fin;
  logic                  issue;
  logic                  last;
  logic                  vld_a;
  logic                  first_a;
  logic [WR_LAT-1:0]     end_pipe;
  logic [WR_LAT-1:0]     last_pipe;
  logic                  last_we;

  // column index, low Q bits of the count
  assign col   = cnt[max_qubits-1:0] & sw.row_mask[max_qubits-1:0];
  assign last  = (cnt == CNT_W'(sw.n_sq - 1'b1));
  // one product per cycle until the count saturates
  assign issue = !sw.clr && !fin;

  // ------------------------------------------------------------
  // product counter
  // ------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!reset_n || sw.clr) begin
      cnt <= '0;
      fin <= 1'b0;
    end else if (issue) begin
      if (last) begin
        fin <= 1'b1;
      end else begin
        cnt <= cnt + 1'b1;
      end
    end
  end

  // ------------------------------------------------------------
  // read addresses
  // ------------------------------------------------------------
  // gate matrix is row-major, count walks it directly
  always_ff @(posedge clk) begin
    gate_addr <= sw.gate_base + addr_t'(cnt);
  end

  // cleared address is 0 so the header shows up on the input read data
  // input sram state starts at word 1, scratchpad at word 0
  always_ff @(posedge clk) begin
    if (!reset_n || sw.clr) begin
      state_rd_addr <= '0;
      vld_a         <= 1'b0;
      first_a       <= 1'b0;
      end_pipe      <= '0;
      last_pipe     <= '0;
      term_valid    <= 1'b0;
      row_first     <= 1'b0;
    end else begin
      if (issue) begin
        state_rd_addr <= addr_t'(col) + addr_t'(!sw.rd_scratch);
      end
      vld_a      <= issue;
      first_a    <= issue && (col == '0);
      end_pipe   <= {end_pipe[WR_LAT-2:0], issue && (col == sw.row_mask[max_qubits-1:0])};
      last_pipe  <= {last_pipe[WR_LAT-2:0], issue && last};
      // read data arrives one cycle after the address
      term_valid <= vld_a;
      row_first  <= first_a;
    end
  end

  // ------------------------------------------------------------
  // write side
  // ------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!reset_n || sw.clr) begin
      out_we     <= 1'b0;
      input_we   <= 1'b0;
      scratch_we <= 1'b0;
      last_we    <= 1'b0;
      wr_row     <= '0;
    end else begin
      // output sram always, plus the state memory not being read
      out_we     <= end_pipe[WR_LAT-1];
      input_we   <= end_pipe[WR_LAT-1] && sw.rd_scratch;
      scratch_we <= end_pipe[WR_LAT-1] && !sw.rd_scratch;
      last_we    <= last_pipe[WR_LAT-1];
      if (end_pipe[WR_LAT-1]) wr_row <= wr_row + 1'b1;
    end
  end

  // row addresses latched with the strobe
  always_ff @(posedge clk) begin
    if (end_pipe[WR_LAT-1]) begin
      out_wr_addr   <= addr_t'(wr_row);
      input_wr_addr <= addr_t'(wr_row) + 1'b1;
    end
  end

  // scratchpad rows line up with output rows
  assign scratch_wr_addr = out_wr_addr;

  // gate done once the last row is in
  always_ff @(posedge clk) begin
    if (!reset_n || sw.clr) begin
      sw.done <= 1'b0;
    end else if (last_we) begin
      sw.done <= 1'b1;
    end
  end

  // ping-pong, never both state memories in one cycle
  we_onehot: assert property (@(posedge clk) disable iff (!reset_n)
    !(input_we && scratch_we));

  // every state write is mirrored to the output sram
  we_mirror: assert property (@(posedge clk) disable iff (!reset_n)
    (input_we || scratch_we) |-> out_we);

endmodule

// ==== cplx_mac.sv ====
module cplx_mac
  import qsim_pkg::*;
(
  input  logic clk,
  input  logic reset_n,
  input  logic a_sel,
  input  amp_t a_scratch,
  input  amp_t a_input,
  input  amp_t b,
  input  logic term_valid,
  input  logic row_first,
  output amp_t result
);

  amp_t  a;
  part_t rr_q;
  part_t ii_q;
  part_t ri_q;
  part_t ir_q;
  amp_t  sum_q;
  amp_t  acc;
  logic  rf_d1;
  logic  rf_d2;

  // state operand from whichever memory this gate reads
  assign a = a_sel ? a_scratch : a_input;

  // ------------------------------------------------------------
  // stage 1 partial products
  // ------------------------------------------------------------
  // zero outside a term so trailing cycles add nothing
  always_ff @(posedge clk) begin
    rr_q <= term_valid ? part_t'(a.re * b.re) : '0;
    ii_q <= term_valid ? part_t'(a.im * b.im) : '0;
    ri_q <= term_valid ? part_t'(a.re * b.im) : '0;
    ir_q <= term_valid ? part_t'(a.im * b.re) : '0;
  end

  // ------------------------------------------------------------
  // stage 2 complex product
  // ------------------------------------------------------------
  always_ff @(posedge clk) begin
    sum_q.re <= rr_q - ii_q;
    sum_q.im <= ri_q + ir_q;
  end

  // row start follows its product down two stages
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      rf_d1 <= 1'b0;
      rf_d2 <= 1'b0;
    end else begin
      rf_d1 <= row_first;
      rf_d2 <= rf_d1;
    end
  end

  // ------------------------------------------------------------
  // stage 3 row accumulate
  // ------------------------------------------------------------
  // first term of a row loads and the rest add
  always_ff @(posedge clk) begin
    if (rf_d2) begin
      acc <= sum_q;
    end else begin
      acc.re <= acc.re + sum_q.re;
      acc.im <= acc.im + sum_q.im;
    end
  end

  // write data for all three state memories
  assign result = acc;

endmodule

// ==== qsim_top.sv ====
module qsim_top
  import qsim_pkg::*;
#(
  parameter int max_qubits = MAX_QUBITS
) (
  input  logic  clk,
  input  logic  reset_n,

  // ------------------------------------------------------------
  // job handshake
  // ------------------------------------------------------------
  input  logic  dut_valid,
  output logic  dut_ready,

  // input state sram
  output logic  q_input_sram_write_enable,
  output addr_t q_input_sram_write_address,
  output amp_t  q_input_sram_write_data,
  output addr_t q_input_sram_read_address,
  input  amp_t  q_input_sram_read_data,

  // scratchpad sram
  output logic  scratchpad_sram_write_enable,
  output addr_t scratchpad_sram_write_address,
  output amp_t  scratchpad_sram_write_data,
  output addr_t scratchpad_sram_read_address,
  input  amp_t  scratchpad_sram_read_data,

  // output state sram, write only
  output logic  q_output_sram_write_enable,
  output addr_t q_output_sram_write_address,
  output amp_t  q_output_sram_write_data,

  // gates sram, read only
  output addr_t q_gates_sram_read_address,
  input  amp_t  q_gates_sram_read_data
);

  sweep_if sw ();

  addr_t state_rd_addr;
  amp_t  result;
  logic  term_valid;
  logic  row_first;

  // both state memories see the same column address
  assign q_input_sram_read_address    = state_rd_addr;
  assign scratchpad_sram_read_address = state_rd_addr;

  // row sum goes wherever a strobe is raised
  assign q_input_sram_write_data    = result;
  assign scratchpad_sram_write_data = result;
  assign q_output_sram_write_data   = result;

  qsim_ctrl #(
    .max_qubits(max_qubits)
  ) u_ctrl (
    .clk      (clk),
    .reset_n  (reset_n),
    .dut_valid(dut_valid),
    .dut_ready(dut_ready),
    .hdr_word (q_input_sram_read_data),
    .sw       (sw.ctrl)
  );

  addr_sweep #(
    .max_qubits(max_qubits)
  ) u_sweep (
    .clk            (clk),
    .reset_n        (reset_n),
    .sw             (sw.sweep),
    .gate_addr      (q_gates_sram_read_address),
    .state_rd_addr  (state_rd_addr),
    .out_wr_addr    (q_output_sram_write_address),
    .input_wr_addr  (q_input_sram_write_address),
    .scratch_wr_addr(scratchpad_sram_write_address),
    .input_we       (q_input_sram_write_enable),
    .scratch_we     (scratchpad_sram_write_enable),
    .out_we         (q_output_sram_write_enable),
    .term_valid     (term_valid),
    .row_first      (row_first)
  );

  cplx_mac u_mac (
    .clk       (clk),
    .reset_n   (reset_n),
    .a_sel     (sw.rd_scratch),
    .a_scratch (scratchpad_sram_read_data),
    .a_input   (q_input_sram_read_data),
    .b         (q_gates_sram_read_data),
    .term_valid(term_valid),
    .row_first (row_first),
    .result    (result)
  );

endmodule

// ==== tb_qsim.sv ====
module tb_qsim
  import qsim_pkg::*;
();

  // backdoor load port targets
  localparam logic [1:0] SEL_IN   = 2'd0;
  localparam logic [1:0] SEL_SCR  = 2'd1;
  localparam logic [1:0] SEL_OUT  = 2'd2;
  localparam logic [1:0] SEL_GATE = 2'd3;
  localparam int MEM_WORDS = 1 << ADDR_W;
  localparam int MAX_N = 1 << MAX_QUBITS;

  logic  clk       = 1'b0;
  logic  reset_n   = 1'b0;
  logic  dut_valid = 1'b0;
  logic  dut_ready;
  logic  in_we;
  addr_t in_waddr;
  amp_t  in_wdata;
  addr_t in_raddr;
  amp_t  in_rdata  = '0;
  logic  scr_we;
  addr_t scr_waddr;
  amp_t  scr_wdata;
  addr_t scr_raddr;
  amp_t  scr_rdata = '0;
  logic  out_we;
  addr_t out_waddr;
  amp_t  out_wdata;
  addr_t gt_raddr;
  amp_t  gt_rdata  = '0;
  // one shared load port for all four memories
  logic       ld_we   = 1'b0;
  logic [1:0] ld_sel  = 2'd0;
  addr_t      ld_addr = '0;
  amp_t       ld_data = '0;
  // job geometry seen by the write monitor
  int n_cur    = 1;
  int wr_count = 0;

  amp_t in_mem   [0:MEM_WORDS-1];
  amp_t scr_mem  [0:MEM_WORDS-1];
  amp_t out_mem  [0:MEM_WORDS-1];
  amp_t gates_mem[0:MEM_WORDS-1];
  // copy of the loaded state vector, the input sram gets overwritten
  amp_t ref_in   [0:MAX_N-1];

  always #4 clk = ~clk;

  qsim_top #(
    .max_qubits(MAX_QUBITS)
  ) dut (
    .clk                          (clk),
    .reset_n                      (reset_n),
    .dut_valid                    (dut_valid),
    .dut_ready                    (dut_ready),
    .q_input_sram_write_enable    (in_we),
    .q_input_sram_write_address   (in_waddr),
    .q_input_sram_write_data      (in_wdata),
    .q_input_sram_read_address    (in_raddr),
    .q_input_sram_read_data       (in_rdata),
    .scratchpad_sram_write_enable (scr_we),
    .scratchpad_sram_write_address(scr_waddr),
    .scratchpad_sram_write_data   (scr_wdata),
    .scratchpad_sram_read_address (scr_raddr),
    .scratchpad_sram_read_data    (scr_rdata),
    .q_output_sram_write_enable   (out_we),
    .q_output_sram_write_address  (out_waddr),
    .q_output_sram_write_data     (out_wdata),
    .q_gates_sram_read_address    (gt_raddr),
    .q_gates_sram_read_data       (gt_rdata)
  );

  // ------------------------------------------------------------
  // sram models, one cycle synchronous read
  // ------------------------------------------------------------
  always @(posedge clk) begin
    if (ld_we && ld_sel == SEL_IN) in_mem[ld_addr] <= ld_data;
    if (in_we) in_mem[in_waddr] <= in_wdata;
    in_rdata <= in_mem[in_raddr];
  end

  always @(posedge clk) begin
    if (ld_we && ld_sel == SEL_SCR) scr_mem[ld_addr] <= ld_data;
    if (scr_we) scr_mem[scr_waddr] <= scr_wdata;
    scr_rdata <= scr_mem[scr_raddr];
  end

  // output sram has no read port
  always @(posedge clk) begin
    if (ld_we && ld_sel == SEL_OUT) out_mem[ld_addr] <= ld_data;
    if (out_we) out_mem[out_waddr] <= out_wdata;
  end

  // gates sram is read only for the dut
  always @(posedge clk) begin
    if (ld_we && ld_sel == SEL_GATE) gates_mem[ld_addr] <= ld_data;
    gt_rdata <= gates_mem[gt_raddr];
  end

  // ------------------------------------------------------------
  // checks
  // ------------------------------------------------------------
  task automatic fail_now();
    $display("TB FAILED");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic check_amp(input string name, input amp_t exp, input amp_t act);
    if (act !== exp) begin
      $display("FAILED time %0t %s expected %h actual %h", $time, name, exp, act);
      fail_now();
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("FAILED time %0t %s expected %b actual %b", $time, name, exp, act);
      fail_now();
    end
  endtask

  task automatic check_addr(input string name, input addr_t exp, input addr_t act);
    if (act !== exp) begin
      $display("FAILED time %0t %s expected %h actual %h", $time, name, exp, act);
      fail_now();
    end
  endtask

  // expected state after the first k gates, wrapping 32-bit complex math
  function automatic amp_t ref_amp(input int q, input int k, input int idx);
    amp_t  cur[0:MAX_N-1];
    amp_t  nxt[0:MAX_N-1];
    amp_t  g;
    part_t sr;
    part_t si;
    int    n;
    n = 1 << q;
    for (int i = 0; i < n; i++) cur[i] = ref_in[i];
    for (int gi = 0; gi < k; gi++) begin
      for (int i = 0; i < n; i++) begin
        sr = '0;
        si = '0;
        // new[i] = sum over j of G[i][j] * state[j]
        for (int j = 0; j < n; j++) begin
          g  = gates_mem[addr_t'(gi * n * n + i * n + j)];
          sr = sr + g.re * cur[j].re - g.im * cur[j].im;
          si = si + g.re * cur[j].im + g.im * cur[j].re;
        end
        nxt[i].re = sr;
        nxt[i].im = si;
      end
      for (int i = 0; i < n; i++) cur[i] = nxt[i];
    end
    return cur[idx];
  endfunction

  // write strobes: row order, ping-pong target, matching addresses
  always @(negedge clk) begin : write_monitor
    int row;
    int gate_idx;
    if (!reset_n) begin
      wr_count = 0;
    end else if (dut_ready) begin
      // idle, nothing may be written
      wr_count = 0;
      check_bit("q_input_sram_write_enable", 1'b0, in_we);
      check_bit("scratchpad_sram_write_enable", 1'b0, scr_we);
      check_bit("q_output_sram_write_enable", 1'b0, out_we);
    end else if (out_we) begin
      row      = wr_count % n_cur;
      gate_idx = wr_count / n_cur;
      check_addr("q_output_sram_write_address", addr_t'(row), out_waddr);
      // even gates write the scratchpad, odd gates the input sram
      check_bit("scratchpad_sram_write_enable", logic'(gate_idx % 2 == 0), scr_we);
      check_bit("q_input_sram_write_enable", logic'(gate_idx % 2 == 1), in_we);
      if (scr_we) check_addr("scratchpad_sram_write_address", addr_t'(row), scr_waddr);
      if (in_we) check_addr("q_input_sram_write_address", addr_t'(row + 1), in_waddr);
      wr_count = wr_count + 1;
    end else begin
      check_bit("q_input_sram_write_enable", 1'b0, in_we);
      check_bit("scratchpad_sram_write_enable", 1'b0, scr_we);
    end
  end

  // ------------------------------------------------------------
  // stimulus helpers
  // ------------------------------------------------------------
  function automatic amp_t rand_amp();
    amp_t r;
    r.re = part_t'($urandom());
    r.im = part_t'($urandom());
    return r;
  endfunction

  // poison word, tagged by memory and the full address
  function automatic amp_t fill_word(input logic [1:0] sel, input addr_t a);
    return {6'h2a, sel, 8'hc3, a, ~a, 16'h0f0f};
  endfunction

  task automatic load_word(input logic [1:0] sel, input addr_t addr, input amp_t data);
    @(posedge clk);
    ld_we   <= 1'b1;
    ld_sel  <= sel;
    ld_addr <= addr;
    ld_data <= data;
  endtask

  // header, state vector, m gates; only while idle
  task automatic load_job(input int q, input int m, input bit identity);
    int   n;
    hdr_t hdr;
    amp_t w;
    n     = 1 << q;
    n_cur = n;
    // stale results from an earlier job must not survive
    for (int a = 0; a < MAX_N; a++) begin
      load_word(SEL_SCR, addr_t'(a), fill_word(SEL_SCR, addr_t'(a)));
      load_word(SEL_OUT, addr_t'(a), fill_word(SEL_OUT, addr_t'(a)));
    end
    hdr.qubits = DATA_W'(q);
    hdr.gates  = DATA_W'(m);
    load_word(SEL_IN, '0, amp_t'(hdr));
    for (int i = 0; i < n; i++) begin
      w         = rand_amp();
      ref_in[i] = w;
      load_word(SEL_IN, addr_t'(i + 1), w);
    end
    for (int g = 0; g < m; g++) begin
      for (int i = 0; i < n; i++) begin
        for (int j = 0; j < n; j++) begin
          if (identity) begin
            w = '0;
            if (i == j) w.re = part_t'(1);
          end else begin
            w = rand_amp();
          end
          load_word(SEL_GATE, addr_t'(g * n * n + i * n + j), w);
        end
      end
    end
    @(posedge clk);
    ld_we <= 1'b0;
  endtask

  task automatic wait_for_ready(input int limit, input string what);
    int cyc;
    cyc = 0;
    @(negedge clk);
    while (!dut_ready) begin
      if (cyc >= limit) begin
        $display("timeout: dut_ready did not rise %s", what);
        fail_now();
      end
      cyc++;
      @(negedge clk);
    end
  endtask

  // pulse dut_valid until the job is taken, then wait for its end
  task automatic run_job(input int q, input int m);
    int cyc;
    int n;
    n   = 1 << q;
    cyc = 0;
    @(posedge clk);
    dut_valid <= 1'b1;
    @(negedge clk);
    while (dut_ready) begin
      if (cyc >= 4) begin
        $display("timeout: job was not accepted after dut_valid");
        fail_now();
      end
      cyc++;
      @(negedge clk);
    end
    @(posedge clk);
    dut_valid <= 1'b0;
    wait_for_ready(m * (n * n + 16) + 32, "at the end of the job");
  endtask

  task automatic check_outputs(input int q, input int m);
    for (int i = 0; i < (1 << q); i++) begin
      check_amp($sformatf("q_output_sram[%0d]", i), ref_amp(q, m, i), out_mem[i]);
    end
  endtask

  // ------------------------------------------------------------
  // test sequence
  // ------------------------------------------------------------
  initial begin
    void'($urandom(27349));

    // reset window, enables held low and ready low
    for (int c = 0; c < 15; c++) begin
      @(negedge clk);
      check_bit("q_input_sram_write_enable", 1'b0, in_we);
      check_bit("scratchpad_sram_write_enable", 1'b0, scr_we);
      check_bit("q_output_sram_write_enable", 1'b0, out_we);
      check_bit("dut_ready", 1'b0, dut_ready);
    end
    @(posedge clk);
    reset_n <= 1'b1;
    wait_for_ready(8, "after reset");
    repeat (4) begin
      @(negedge clk);
      check_bit("q_output_sram_write_enable", 1'b0, out_we);
    end

    // identity gate, pure routing and addressing
    load_job(1, 1, 1'b1);
    run_job(1, 1);
    for (int i = 0; i < 2; i++) begin
      check_amp($sformatf("q_output_sram[%0d]", i), ref_in[i], out_mem[i]);
    end

    // three gates, both ping-pong directions
    load_job(2, 3, 1'b0);
    run_job(2, 3);
    check_outputs(2, 3);
    for (int i = 0; i < 4; i++) begin
      check_amp($sformatf("scratchpad_sram[%0d]", i), ref_amp(2, 3, i), scr_mem[i]);
      check_amp($sformatf("q_input_sram[%0d]", i + 1), ref_amp(2, 2, i), in_mem[i + 1]);
    end

    // largest state vector
    load_job(4, 2, 1'b0);
    run_job(4, 2);
    check_outputs(4, 2);

    // back to back, smaller vector after a larger one
    load_job(3, 2, 1'b0);
    run_job(3, 2);
    check_outputs(3, 2);
    load_job(2, 1, 1'b0);
    run_job(2, 1);
    check_outputs(2, 1);

    $display("TB PASSED");
    $finish;
  end

endmodule

// ==== sim.f ====
qsim_pkg.sv
sweep_if.sv
qsim_ctrl.sv
addr_sweep.sv
cplx_mac.sv
qsim_top.sv
tb_qsim.sv

// ==== Makefile ====
# Verilator build and run for the quantum state simulator

VERILATOR ?= verilator
TOP       ?= tb_qsim
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FILELIST  ?= sim.f
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(filter %.sv %.v,$(shell cat $(FILELIST)))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# pass or fail comes from the log, not the exit status of tee
run: $(BIN)
	./$(BIN) 2>&1 | tee $(LOG)
	@grep -qx "TB PASSED" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
